// File: hdl/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data and address width
`define CORE_XLEN 32

// architectural registers, r0 reads zero
`define CORE_NREG 32

// fetch buffer entries
`define CORE_IB_DEPTH 2

// r3 major opcodes, instruction bits 31:15
`define CORE_OP_ADD_W 17'h00020
`define CORE_OP_SUB_W 17'h00022
`define CORE_OP_AND   17'h00029
`define CORE_OP_OR    17'h0002a
`define CORE_OP_XOR   17'h0002b

// ri12 opcodes, instruction bits 31:22
`define CORE_OP_ADDI_W 10'h00a
`define CORE_OP_ANDI   10'h00d
`define CORE_OP_ORI    10'h00e

`endif

// File: hdl/core_pkg.sv
`default_nettype none

`include "core_cfg.svh"

package core_pkg;

    // one data word
    typedef logic [`CORE_XLEN-1:0] word_t;

    // register index
    typedef logic [$clog2(`CORE_NREG)-1:0] reg_idx_t;

    // alu operations
    // immediate forms keep their own codes so the decoded item stays readable
    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_AND  = 4'd3,
        ALU_OR   = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_ADDI = 4'd6,
        ALU_ANDI = 4'd7,
        ALU_ORI  = 4'd8
    } alu_op_e;

    // three-register format
    typedef struct packed {
        logic [16:0] opcode17;
        reg_idx_t    rk;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } inst_r3_t;

    // register plus 12-bit immediate format
    typedef struct packed {
        logic [9:0]  opcode10;
        logic [11:0] imm12;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } inst_ri12_t;

    // both views of one instruction word
    // rj and rd sit in the same bits in either view
    typedef union packed {
        inst_r3_t   r3;
        inst_ri12_t ri12;
    } inst_u;

endpackage

`default_nettype wire

// File: hdl/fetch_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module fetch_buffer import core_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    // from outside
    input  logic  in_valid_i,
    output logic  in_ready_o,
    input  word_t in_pc_i,
    input  word_t in_inst_i,
    // to decode
    output logic  out_valid_o,
    input  logic  out_ready_i,
    output word_t out_pc_o,
    output word_t out_inst_o
);

    localparam int DEPTH = `CORE_IB_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    word_t            pc_mem   [DEPTH];
    word_t            inst_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;
    logic             push;
    logic             pop;

    // circular pointer step
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push    = in_valid_i && in_ready_o;
    assign pop     = out_valid_o && out_ready_i;
    assign count_d = count_q + CNT_W'(push) - CNT_W'(pop);

    // oldest entry faces decode
    assign out_valid_o = (count_q != '0);
    assign out_pc_o    = pc_mem[rd_ptr_q];
    assign out_inst_o  = inst_mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            in_ready_o <= 1'b1;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q <= count_d;
            // ready from next occupancy, so no path back from decode
            in_ready_o <= (count_d < CNT_W'(DEPTH));
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr_q]   <= in_pc_i;
            inst_mem[wr_ptr_q] <= in_inst_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module regfile import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    // combinational reads
    input  reg_idx_t raddr_a_i,
    input  reg_idx_t raddr_b_i,
    output word_t    rdata_a_o,
    output word_t    rdata_b_o,
    // write from commit
    input  logic     we_i,
    input  reg_idx_t waddr_i,
    input  word_t    wdata_i
);

    word_t regs_q [`CORE_NREG];

    // r0 always reads zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CORE_NREG; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module decode_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    // from fetch buffer
    input  logic     ib_valid_i,
    output logic     ib_ready_o,
    input  word_t    ib_pc_i,
    input  word_t    ib_inst_i,
    // register file reads
    output reg_idx_t rf_raddr_a_o,
    output reg_idx_t rf_raddr_b_o,
    input  word_t    rf_rdata_a_i,
    input  word_t    rf_rdata_b_i,
    // writer at the execute input
    input  logic     ex_in_valid_i,
    input  logic     ex_in_we_i,
    input  reg_idx_t ex_in_rd_i,
    input  word_t    ex_in_data_i,
    // writer in the execute result register
    input  logic     ex_res_valid_i,
    input  logic     ex_res_we_i,
    input  reg_idx_t ex_res_rd_i,
    input  word_t    ex_res_data_i,
    // writer in the commit register
    input  logic     wb_valid_i,
    input  logic     wb_we_i,
    input  reg_idx_t wb_rd_i,
    input  word_t    wb_data_i,
    // to execute
    output logic     id_valid_o,
    input  logic     id_ready_i,
    output word_t    id_a_o,
    output word_t    id_b_o,
    output alu_op_e  id_op_o,
    output reg_idx_t id_rd_o,
    output logic     id_we_o,
    output word_t    id_pc_o,
    output word_t    id_inst_o
);

    inst_u   inst;
    alu_op_e op_d;
    word_t   opa_d;
    word_t   opb_byp;
    word_t   opb_d;
    logic    we_d;

    // pick the youngest in-flight writer of idx, else the register file
    function automatic word_t sel_operand(input reg_idx_t idx, input word_t rf_val);
        word_t val;
        val = rf_val;
        if (idx != '0) begin
            // oldest first, younger matches overwrite
            if (wb_valid_i && wb_we_i && (wb_rd_i == idx)) begin
                val = wb_data_i;
            end
            if (ex_res_valid_i && ex_res_we_i && (ex_res_rd_i == idx)) begin
                val = ex_res_data_i;
            end
            if (ex_in_valid_i && ex_in_we_i && (ex_in_rd_i == idx)) begin
                val = ex_in_data_i;
            end
        end
        return val;
    endfunction

    assign inst = ib_inst_i;

    // rj is shared by both views, rk only matters for r3
    assign rf_raddr_a_o = inst.r3.rj;
    assign rf_raddr_b_o = inst.r3.rk;

    // take a new item when empty or when the held one leaves
    assign ib_ready_o = !id_valid_o || id_ready_i;

    always_comb begin
        // r3 opcodes first, then the ri12 ones
        case (inst.r3.opcode17)
            `CORE_OP_ADD_W: op_d = ALU_ADD;
            `CORE_OP_SUB_W: op_d = ALU_SUB;
            `CORE_OP_AND:   op_d = ALU_AND;
            `CORE_OP_OR:    op_d = ALU_OR;
            `CORE_OP_XOR:   op_d = ALU_XOR;
            default: begin
                case (inst.ri12.opcode10)
                    `CORE_OP_ADDI_W: op_d = ALU_ADDI;
                    `CORE_OP_ANDI:   op_d = ALU_ANDI;
                    `CORE_OP_ORI:    op_d = ALU_ORI;
                    default:         op_d = ALU_NOP;
                endcase
            end
        endcase

        opa_d   = sel_operand(inst.r3.rj, rf_rdata_a_i);
        opb_byp = sel_operand(inst.r3.rk, rf_rdata_b_i);

        // operand b source
        case (op_d)
            ALU_ADDI: begin
                opb_d = {{(`CORE_XLEN-12){inst.ri12.imm12[11]}}, inst.ri12.imm12};
            end
            ALU_ANDI, ALU_ORI: begin
                opb_d = {{(`CORE_XLEN-12){1'b0}}, inst.ri12.imm12};
            end
            default: begin
                opb_d = opb_byp;
            end
        endcase

        // unknown encodings and r0 targets commit without a write
        we_d = (op_d != ALU_NOP) && (inst.r3.rd != '0);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_valid_o <= 1'b0;
        end else if (ib_ready_o) begin
            id_valid_o <= ib_valid_i;
        end
    end

    // decoded item, held while execute stalls
    always_ff @(posedge clk) begin
        if (ib_valid_i && ib_ready_o) begin
            id_a_o    <= opa_d;
            id_b_o    <= opb_d;
            id_op_o   <= op_d;
            id_rd_o   <= inst.r3.rd;
            id_we_o   <= we_d;
            id_pc_o   <= ib_pc_i;
            id_inst_o <= ib_inst_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/exe_stage.sv
`timescale 1ns/10ps
`default_nettype none

module exe_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    // from decode
    input  logic     id_valid_i,
    output logic     id_ready_o,
    input  word_t    id_a_i,
    input  word_t    id_b_i,
    input  alu_op_e  id_op_i,
    input  reg_idx_t id_rd_i,
    input  logic     id_we_i,
    input  word_t    id_pc_i,
    input  word_t    id_inst_i,
    // to write-back
    output logic     ex_valid_o,
    input  logic     ex_ready_i,
    output word_t    ex_result_o,
    output reg_idx_t ex_rd_o,
    output logic     ex_we_o,
    output word_t    ex_pc_o,
    output word_t    ex_inst_o,
    // input item as a writer
    output logic     ex_in_valid_o,
    output logic     ex_in_we_o,
    output reg_idx_t ex_in_rd_o,
    output word_t    ex_in_data_o,
    // held item as a writer
    output logic     ex_res_valid_o,
    output logic     ex_res_we_o,
    output reg_idx_t ex_res_rd_o,
    output word_t    ex_res_data_o
);

    word_t alu_res;

    // 32-bit wraparound, immediates already extended in decode
    always_comb begin
        case (id_op_i)
            ALU_ADD, ALU_ADDI: alu_res = id_a_i + id_b_i;
            ALU_SUB:           alu_res = id_a_i - id_b_i;
            ALU_AND, ALU_ANDI: alu_res = id_a_i & id_b_i;
            ALU_OR, ALU_ORI:   alu_res = id_a_i | id_b_i;
            ALU_XOR:           alu_res = id_a_i ^ id_b_i;
            default:           alu_res = '0;
        endcase
    end

    assign id_ready_o = !ex_valid_o || ex_ready_i;

    // the result is already known while the item waits at the input
    assign ex_in_valid_o = id_valid_i;
    assign ex_in_we_o    = id_we_i;
    assign ex_in_rd_o    = id_rd_i;
    assign ex_in_data_o  = alu_res;

    assign ex_res_valid_o = ex_valid_o;
    assign ex_res_we_o    = ex_we_o;
    assign ex_res_rd_o    = ex_rd_o;
    assign ex_res_data_o  = ex_result_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_valid_o <= 1'b0;
        end else if (id_ready_o) begin
            ex_valid_o <= id_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid_i && id_ready_o) begin
            ex_result_o <= alu_res;
            ex_rd_o     <= id_rd_i;
            ex_we_o     <= id_we_i;
            ex_pc_o     <= id_pc_i;
            ex_inst_o   <= id_inst_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/wb_stage.sv
`timescale 1ns/10ps
`default_nettype none

module wb_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    // from execute
    input  logic     ex_valid_i,
    output logic     ex_ready_o,
    input  word_t    ex_result_i,
    input  reg_idx_t ex_rd_i,
    input  logic     ex_we_i,
    input  word_t    ex_pc_i,
    input  word_t    ex_inst_i,
    // commit port
    output logic     commit_valid_o,
    input  logic     commit_ready_i,
    output word_t    commit_pc_o,
    output word_t    commit_inst_o,
    output logic     commit_wen_o,
    output reg_idx_t commit_wnum_o,
    output word_t    commit_wdata_o,
    // register file write
    output logic     rf_we_o,
    output reg_idx_t rf_waddr_o,
    output word_t    rf_wdata_o,
    // commit register as a writer
    output logic     wb_valid_o,
    output logic     wb_we_o,
    output reg_idx_t wb_rd_o,
    output word_t    wb_data_o
);

    logic we_q;
    logic commit_fire;

    assign commit_fire = commit_valid_o && commit_ready_i;
    assign ex_ready_o  = !commit_valid_o || commit_ready_i;

    assign commit_wen_o = commit_valid_o && we_q;

    // register file updates exactly once, on the commit transfer
    assign rf_we_o    = commit_fire && we_q;
    assign rf_waddr_o = commit_wnum_o;
    assign rf_wdata_o = commit_wdata_o;

    // still the youngest value until the write lands
    assign wb_valid_o = commit_valid_o;
    assign wb_we_o    = we_q;
    assign wb_rd_o    = commit_wnum_o;
    assign wb_data_o  = commit_wdata_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            commit_valid_o <= 1'b0;
        end else if (ex_ready_o) begin
            commit_valid_o <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid_i && ex_ready_o) begin
            commit_pc_o    <= ex_pc_i;
            commit_inst_o  <= ex_inst_i;
            commit_wnum_o  <= ex_rd_i;
            commit_wdata_o <= ex_result_i;
            we_q           <= ex_we_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    // instruction input
    input  logic     inst_valid_i,
    output logic     inst_ready_o,
    input  word_t    inst_pc_i,
    input  word_t    inst_i,
    // commit port
    output logic     commit_valid_o,
    input  logic     commit_ready_i,
    output word_t    commit_pc_o,
    output word_t    commit_inst_o,
    output logic     commit_wen_o,
    output reg_idx_t commit_wnum_o,
    output word_t    commit_wdata_o
);

    // fetch buffer to decode
    logic     ib_valid;
    logic     ib_ready;
    word_t    ib_pc;
    word_t    ib_inst;

    // register file read and write
    reg_idx_t rf_raddr_a;
    reg_idx_t rf_raddr_b;
    word_t    rf_rdata_a;
    word_t    rf_rdata_b;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    // decode to execute
    logic     id_valid;
    logic     id_ready;
    word_t    id_a;
    word_t    id_b;
    alu_op_e  id_op;
    reg_idx_t id_rd;
    logic     id_we;
    word_t    id_pc;
    word_t    id_inst;

    // execute to write-back
    logic     ex_valid;
    logic     ex_ready;
    word_t    ex_result;
    reg_idx_t ex_rd;
    logic     ex_we;
    word_t    ex_pc;
    word_t    ex_inst;

    // writer descriptors back into decode, youngest first
    logic     ex_in_valid;
    logic     ex_in_we;
    reg_idx_t ex_in_rd;
    word_t    ex_in_data;
    logic     ex_res_valid;
    logic     ex_res_we;
    reg_idx_t ex_res_rd;
    word_t    ex_res_data;
    logic     wb_byp_valid;
    logic     wb_byp_we;
    reg_idx_t wb_byp_rd;
    word_t    wb_byp_data;

    fetch_buffer i_fetch_buffer (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (inst_valid_i),
        .in_ready_o  (inst_ready_o),
        .in_pc_i     (inst_pc_i),
        .in_inst_i   (inst_i),
        .out_valid_o (ib_valid),
        .out_ready_i (ib_ready),
        .out_pc_o    (ib_pc),
        .out_inst_o  (ib_inst)
    );

    decode_stage i_decode_stage (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .ib_valid_i      (ib_valid),
        .ib_ready_o      (ib_ready),
        .ib_pc_i         (ib_pc),
        .ib_inst_i       (ib_inst),
        .rf_raddr_a_o    (rf_raddr_a),
        .rf_raddr_b_o    (rf_raddr_b),
        .rf_rdata_a_i    (rf_rdata_a),
        .rf_rdata_b_i    (rf_rdata_b),
        .ex_in_valid_i   (ex_in_valid),
        .ex_in_we_i      (ex_in_we),
        .ex_in_rd_i      (ex_in_rd),
        .ex_in_data_i    (ex_in_data),
        .ex_res_valid_i  (ex_res_valid),
        .ex_res_we_i     (ex_res_we),
        .ex_res_rd_i     (ex_res_rd),
        .ex_res_data_i   (ex_res_data),
        .wb_valid_i      (wb_byp_valid),
        .wb_we_i         (wb_byp_we),
        .wb_rd_i         (wb_byp_rd),
        .wb_data_i       (wb_byp_data),
        .id_valid_o      (id_valid),
        .id_ready_i      (id_ready),
        .id_a_o          (id_a),
        .id_b_o          (id_b),
        .id_op_o         (id_op),
        .id_rd_o         (id_rd),
        .id_we_o         (id_we),
        .id_pc_o         (id_pc),
        .id_inst_o       (id_inst)
    );

    regfile i_regfile (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

    exe_stage i_exe_stage (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .id_valid_i      (id_valid),
        .id_ready_o      (id_ready),
        .id_a_i          (id_a),
        .id_b_i          (id_b),
        .id_op_i         (id_op),
        .id_rd_i         (id_rd),
        .id_we_i         (id_we),
        .id_pc_i         (id_pc),
        .id_inst_i       (id_inst),
        .ex_valid_o      (ex_valid),
        .ex_ready_i      (ex_ready),
        .ex_result_o     (ex_result),
        .ex_rd_o         (ex_rd),
        .ex_we_o         (ex_we),
        .ex_pc_o         (ex_pc),
        .ex_inst_o       (ex_inst),
        .ex_in_valid_o   (ex_in_valid),
        .ex_in_we_o      (ex_in_we),
        .ex_in_rd_o      (ex_in_rd),
        .ex_in_data_o    (ex_in_data),
        .ex_res_valid_o  (ex_res_valid),
        .ex_res_we_o     (ex_res_we),
        .ex_res_rd_o     (ex_res_rd),
        .ex_res_data_o   (ex_res_data)
    );

    wb_stage i_wb_stage (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .ex_valid_i     (ex_valid),
        .ex_ready_o     (ex_ready),
        .ex_result_i    (ex_result),
        .ex_rd_i        (ex_rd),
        .ex_we_i        (ex_we),
        .ex_pc_i        (ex_pc),
        .ex_inst_i      (ex_inst),
        .commit_valid_o (commit_valid_o),
        .commit_ready_i (commit_ready_i),
        .commit_pc_o    (commit_pc_o),
        .commit_inst_o  (commit_inst_o),
        .commit_wen_o   (commit_wen_o),
        .commit_wnum_o  (commit_wnum_o),
        .commit_wdata_o (commit_wdata_o),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .wb_valid_o     (wb_byp_valid),
        .wb_we_o        (wb_byp_we),
        .wb_rd_o        (wb_byp_rd),
        .wb_data_o      (wb_byp_data)
    );

endmodule

`default_nettype wire

// File: dv/tb_core_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_cfg.svh"

module tb_core_top import core_pkg::*; ();

    localparam int unsigned SEED = 32'h72910acb;
    localparam int TIMEOUT_CYCLES = 500;
    localparam int NUM_RANDOM = 300;

    // one expected commit in issue order
    typedef struct packed {
        word_t    pc;
        word_t    inst;
        logic     wen;
        reg_idx_t wnum;
        word_t    wdata;
    } exp_t;

    logic     clk;
    logic     rst_n_i;
    logic     inst_valid_i;
    logic     inst_ready_o;
    word_t    inst_pc_i;
    word_t    inst_i;
    logic     commit_valid_o;
    logic     commit_ready_i;
    word_t    commit_pc_o;
    word_t    commit_inst_o;
    logic     commit_wen_o;
    reg_idx_t commit_wnum_o;
    word_t    commit_wdata_o;

    exp_t  exp_q [$];
    word_t model_regs [`CORE_NREG];
    word_t pc_next;
    logic  bp_on;
    int    sent;
    int    committed;
    int    cmp_errors;
    int    drv_errors;
    int    timeouts;

    core_top i_dut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .inst_valid_i   (inst_valid_i),
        .inst_ready_o   (inst_ready_o),
        .inst_pc_i      (inst_pc_i),
        .inst_i         (inst_i),
        .commit_valid_o (commit_valid_o),
        .commit_ready_i (commit_ready_i),
        .commit_pc_o    (commit_pc_o),
        .commit_inst_o  (commit_inst_o),
        .commit_wen_o   (commit_wen_o),
        .commit_wnum_o  (commit_wnum_o),
        .commit_wdata_o (commit_wdata_o)
    );

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // commit back-pressure is random only while enabled
    // enable sampled on the rising edge, away from where it changes
    initial begin
        logic bp_now;
        commit_ready_i = 1'b1;
        forever begin
            @(posedge clk);
            bp_now = bp_on;
            @(negedge clk);
            commit_ready_i = bp_now ? (($urandom % 3) != 0) : 1'b1;
        end
    end

    function automatic word_t r3_word(input logic [16:0] op, input reg_idx_t rd,
                                      input reg_idx_t rj, input reg_idx_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic word_t ri12_word(input logic [9:0] op, input reg_idx_t rd,
                                        input reg_idx_t rj, input logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    // reference model advances the model registers in program order
    function automatic exp_t expect_commit(input word_t pc, input word_t inst);
        exp_t  e;
        word_t a;
        word_t b;
        word_t imm_s;
        word_t imm_z;
        word_t res;
        logic  known;
        a     = model_regs[inst[9:5]];
        b     = model_regs[inst[14:10]];
        imm_s = {{20{inst[21]}}, inst[21:10]};
        imm_z = {20'b0, inst[21:10]};
        res   = '0;
        known = 1'b1;
        case (inst[31:15])
            `CORE_OP_ADD_W: res = a + b;
            `CORE_OP_SUB_W: res = a - b;
            `CORE_OP_AND:   res = a & b;
            `CORE_OP_OR:    res = a | b;
            `CORE_OP_XOR:   res = a ^ b;
            default: begin
                case (inst[31:22])
                    `CORE_OP_ADDI_W: res = a + imm_s;
                    `CORE_OP_ANDI:   res = a & imm_z;
                    `CORE_OP_ORI:    res = a | imm_z;
                    default:         known = 1'b0;
                endcase
            end
        endcase
        e.pc    = pc;
        e.inst  = inst;
        e.wen   = known && (inst[4:0] != 5'd0);
        e.wnum  = inst[4:0];
        e.wdata = res;
        // r0 is never written and stays zero
        if (e.wen) begin
            model_regs[inst[4:0]] = res;
        end
        return e;
    endfunction

    // small register window so dependencies are frequent
    function automatic word_t random_inst();
        reg_idx_t    rd;
        reg_idx_t    rj;
        reg_idx_t    rk;
        logic [11:0] imm;
        int          kind;
        word_t       w;
        rd   = 5'($urandom % 8);
        rj   = 5'($urandom % 8);
        rk   = 5'($urandom % 8);
        imm  = 12'($urandom);
        kind = int'($urandom % 10);
        case (kind)
            0:       w = r3_word(`CORE_OP_ADD_W, rd, rj, rk);
            1:       w = r3_word(`CORE_OP_SUB_W, rd, rj, rk);
            2:       w = r3_word(`CORE_OP_AND, rd, rj, rk);
            3:       w = r3_word(`CORE_OP_OR, rd, rj, rk);
            4:       w = r3_word(`CORE_OP_XOR, rd, rj, rk);
            5:       w = ri12_word(`CORE_OP_ADDI_W, rd, rj, imm);
            6:       w = ri12_word(`CORE_OP_ANDI, rd, rj, imm);
            7:       w = ri12_word(`CORE_OP_ORI, rd, rj, imm);
            // opcode10 of all ones matches nothing
            8:       w = {10'h3ff, 22'($urandom)};
            default: w = r3_word(`CORE_OP_XOR, 5'd0, rj, rk);
        endcase
        return w;
    endfunction

    task automatic check_value(input string what, input word_t got, input word_t exp,
                               inout int err_count);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic finish_run();
        $display("%0d sent, %0d committed, %0d mismatches, %0d other errors, %0d timeouts",
                 sent, committed, cmp_errors, drv_errors, timeouts);
        if (cmp_errors == 0 && drv_errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: %s did not happen within %0d cycles",
                 $time, what, TIMEOUT_CYCLES);
        timeouts++;
    endtask

    // called just after a falling edge and returns on one
    // nothing more is sent once a wait has timed out
    task automatic send_inst(input word_t inst, input int gap);
        int   waited;
        logic taken;
        if (timeouts != 0) begin
            return;
        end
        inst_valid_i = 1'b1;
        inst_pc_i    = pc_next;
        inst_i       = inst;
        exp_q.push_back(expect_commit(pc_next, inst));
        sent++;
        pc_next = pc_next + 32'd4;
        waited  = 0;
        taken   = 1'b0;
        while (!taken && timeouts == 0) begin
            @(posedge clk);
            if (inst_ready_o) begin
                taken = 1'b1;
            end else begin
                waited++;
                if (waited >= TIMEOUT_CYCLES) begin
                    report_timeout("input transfer on inst_ready_o");
                end
            end
        end
        @(negedge clk);
        inst_valid_i = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    // compare on every commit transfer
    always @(posedge clk) begin
        exp_t e;
        if (rst_n_i && commit_valid_o && commit_ready_i) begin
            committed++;
            if (exp_q.size() == 0) begin
                $display("error at %0t ns: commit of pc %h with nothing outstanding",
                         $time, commit_pc_o);
                cmp_errors++;
            end else begin
                e = exp_q.pop_front();
                check_value("commit_pc_o", commit_pc_o, e.pc, cmp_errors);
                check_value("commit_inst_o", commit_inst_o, e.inst, cmp_errors);
                check_value("commit_wen_o", 32'(commit_wen_o), 32'(e.wen), cmp_errors);
                if (e.wen) begin
                    check_value("commit_wnum_o", 32'(commit_wnum_o), 32'(e.wnum), cmp_errors);
                    check_value("commit_wdata_o", commit_wdata_o, e.wdata, cmp_errors);
                end
            end
        end
    end

    initial begin
        int seed_ret;
        int gap;
        int waited;
        seed_ret     = $urandom(SEED);
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_pc_i    = '0;
        inst_i       = '0;
        bp_on        = 1'b0;
        pc_next      = 32'h1c000000;
        sent         = 0;
        committed    = 0;
        cmp_errors   = 0;
        drv_errors   = 0;
        timeouts     = 0;
        for (int r = 0; r < `CORE_NREG; r++) begin
            model_regs[r] = '0;
        end
        repeat (4) @(negedge clk);
        rst_n_i = 1'b1;

        // idle state out of reset
        check_value("commit_valid_o after reset", 32'(commit_valid_o), 32'd0, drv_errors);
        check_value("inst_ready_o after reset", 32'(inst_ready_o), 32'd1, drv_errors);
        send_inst(r3_word(`CORE_OP_ADD_W, 5'd5, 5'd0, 5'd0), 0);

        // wraparound corners
        send_inst(ri12_word(`CORE_OP_ADDI_W, 5'd1, 5'd0, 12'hfff), 0);
        send_inst(ri12_word(`CORE_OP_ADDI_W, 5'd2, 5'd0, 12'h001), 0);
        send_inst(r3_word(`CORE_OP_ADD_W, 5'd3, 5'd1, 5'd2), 0);
        send_inst(r3_word(`CORE_OP_SUB_W, 5'd4, 5'd0, 5'd2), 0);
        send_inst(ri12_word(`CORE_OP_ADDI_W, 5'd5, 5'd0, 12'h7ff), 0);
        // doubling walks r5 up to the top bits
        for (int i = 0; i < 20; i++) begin
            send_inst(r3_word(`CORE_OP_ADD_W, 5'd5, 5'd5, 5'd5), 0);
        end
        send_inst(r3_word(`CORE_OP_ADD_W, 5'd6, 5'd5, 5'd5), 0);
        send_inst(r3_word(`CORE_OP_SUB_W, 5'd7, 5'd0, 5'd5), 0);

        // random contents in r1 to r7 before each r3 op
        for (int i = 1; i < 8; i++) begin
            send_inst(ri12_word(`CORE_OP_ADDI_W, 5'(i), 5'd0, 12'($urandom)), 0);
            repeat ($urandom % 21) begin
                send_inst(r3_word(`CORE_OP_ADD_W, 5'(i), 5'(i), 5'(i)), 0);
            end
            send_inst(ri12_word(`CORE_OP_ORI, 5'(i), 5'(i), 12'($urandom)), 0);
            send_inst(r3_word(`CORE_OP_XOR, 5'(i), 5'(i), 5'(i - 1)), 0);
        end
        send_inst(r3_word(`CORE_OP_ADD_W, 5'd8, 5'd1, 5'd2), 0);
        send_inst(r3_word(`CORE_OP_SUB_W, 5'd9, 5'd3, 5'd4), 0);
        send_inst(r3_word(`CORE_OP_AND, 5'd10, 5'd5, 5'd6), 0);
        send_inst(r3_word(`CORE_OP_OR, 5'd11, 5'd7, 5'd1), 0);
        send_inst(r3_word(`CORE_OP_XOR, 5'd12, 5'd2, 5'd3), 0);

        // immediates with the top bit set
        send_inst(ri12_word(`CORE_OP_ADDI_W, 5'd1, 5'd0, 12'hfff), 0);
        send_inst(ri12_word(`CORE_OP_ADDI_W, 5'd13, 5'd9, 12'h800), 0);
        send_inst(ri12_word(`CORE_OP_ANDI, 5'd14, 5'd1, 12'h800), 0);
        send_inst(ri12_word(`CORE_OP_ANDI, 5'd15, 5'd1, 12'hfff), 0);
        send_inst(ri12_word(`CORE_OP_ORI, 5'd16, 5'd0, 12'hfff), 0);
        send_inst(ri12_word(`CORE_OP_ORI, 5'd17, 5'd4, 12'h800), 0);

        // back-to-back chain reading results one, two and three ahead
        send_inst(ri12_word(`CORE_OP_ADDI_W, 5'd20, 5'd0, 12'h123), 0);
        send_inst(r3_word(`CORE_OP_ADD_W, 5'd21, 5'd20, 5'd20), 0);
        send_inst(r3_word(`CORE_OP_SUB_W, 5'd22, 5'd21, 5'd20), 0);
        send_inst(r3_word(`CORE_OP_XOR, 5'd20, 5'd22, 5'd21), 0);
        send_inst(r3_word(`CORE_OP_OR, 5'd21, 5'd20, 5'd22), 0);
        send_inst(ri12_word(`CORE_OP_ADDI_W, 5'd22, 5'd21, 12'hf00), 0);
        send_inst(r3_word(`CORE_OP_AND, 5'd20, 5'd22, 5'd21), 0);
        // r21 sits in the commit register here
        send_inst(r3_word(`CORE_OP_OR, 5'd23, 5'd21, 5'd0), 0);

        // r0 targets and unknown encodings followed by r0 reads
        send_inst(r3_word(`CORE_OP_ADD_W, 5'd0, 5'd1, 5'd2), 0);
        send_inst(ri12_word(`CORE_OP_ORI, 5'd0, 5'd1, 12'hfff), 0);
        send_inst(32'h00000000, 0);
        send_inst(32'hffffffff, 0);
        send_inst(r3_word(`CORE_OP_ADD_W, 5'd6, 5'd0, 5'd0), 0);
        send_inst(r3_word(`CORE_OP_OR, 5'd7, 5'd0, 5'd1), 0);

        // random program under back-pressure and input gaps
        bp_on = 1'b1;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            gap = (($urandom % 4) == 0) ? int'($urandom % 3) : 0;
            send_inst(random_inst(), gap);
        end

        // drain everything still in flight
        waited = 0;
        while (exp_q.size() != 0 && timeouts == 0) begin
            @(negedge clk);
            waited++;
            if (waited >= TIMEOUT_CYCLES) begin
                report_timeout("drain of outstanding commits");
            end
        end
        bp_on = 1'b0;
        // quiet window where an extra commit would show up
        repeat (10) @(negedge clk);
        check_value("commit count", word_t'(committed), word_t'(sent), drv_errors);
        finish_run();
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hdl
hdl/core_pkg.sv
hdl/fetch_buffer.sv
hdl/regfile.sv
hdl/decode_stage.sv
hdl/exe_stage.sv
hdl/wb_stage.sv
hdl/core_top.sv
dv/tb_core_top.sv

// File: Makefile
TOP := tb_core_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f vlog.f --top-module $(TOP) \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" sim.log || { echo "no pass line found in sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log
